// ==== common/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// first fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

// register tapped out as gp
`define CORE_GP_REG 5'd3

`endif

// ==== common/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal
    } branch_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;
        logic     use_pc;
        mem_op_e  mem_op;
        branch_e  branch;
        logic     rf_wen;
        reg_idx_t wb_addr;
        logic     is_exit;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        ctrl_t ctrl;
        word_t rs1_val;
        word_t rs2_val;
        word_t imm;
    } id_ex_t;

    typedef struct packed {
        logic  valid;
        ctrl_t ctrl;
        word_t alu_out;
        word_t store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     rf_wen;
        reg_idx_t wb_addr;
        word_t    wb_data;
        logic     is_exit;
    } mem_wb_t;

    // pending register write seen by the hazard check
    typedef struct packed {
        logic     busy;
        reg_idx_t addr;
    } writer_t;

endpackage

// ==== verilog/register_file.sv ====
`include "core_macros.svh"

module register_file (
    input  logic               clk,
    input  logic               arst_n,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t    rs1_val,
    output core_pkg::word_t    rs2_val,
    input  logic               wen,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata,
    output core_pkg::word_t    gp
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // reads see the old value during a write
    assign rs1_val = regs[rs1_idx];
    assign rs2_val = regs[rs2_idx];
    assign gp      = regs[`CORE_GP_REG];

    assert property (@(posedge clk) disable iff (!arst_n) wen && waddr == '0 |=> regs[0] == '0);

endmodule

// ==== fetch/fetch_stage.sv ====
`include "core_macros.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             arst_n,
    output logic             imem_start,
    output core_pkg::word_t  imem_addr,
    input  logic             imem_ready,
    input  core_pkg::word_t  imem_data,
    input  logic             imem_valid,
    input  logic             stall,
    input  logic             redirect,
    input  core_pkg::word_t  redirect_target,
    input  logic             halt,
    output core_pkg::if_id_t if_out
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_ready,
        wait_data
    } state_e;

    state_e state;
    word_t  pc;
    word_t  req_pc;
    word_t  fetch_pc;
    logic   drop;
    logic   resp_live;
    logic   issue;
    if_id_t buf_q;

    assign imem_start = state == wait_ready;
    assign imem_addr  = req_pc;
    assign resp_live  = state == wait_data && imem_valid && !drop;
    // hold off while a stalled response sits in the buffer
    assign issue      = state == idle && !halt && !buf_q.valid;
    assign fetch_pc   = redirect ? redirect_target : pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= idle;
            pc     <= `CORE_RESET_PC;
            req_pc <= `CORE_RESET_PC;
            drop   <= 1'b0;
        end else begin
            if (issue) begin
                req_pc <= fetch_pc;
                pc     <= fetch_pc + 32'd4;
            end else if (redirect) begin
                pc <= redirect_target;
            end

            case (state)
                idle:       if (issue) state <= wait_ready;
                wait_ready: if (imem_ready) state <= wait_data;
                wait_data:  if (imem_valid) state <= idle;
                default:    state <= idle;
            endcase

            // request in flight belongs to the old path
            if (redirect && (state == wait_ready || (state == wait_data && !imem_valid))) begin
                drop <= 1'b1;
            end else if (state == wait_data && imem_valid) begin
                drop <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_q <= '0;
        end else if (redirect || !stall) begin
            buf_q.valid <= 1'b0;
        end else if (resp_live) begin
            buf_q <= '{valid: 1'b1, pc: req_pc, inst: imem_data};
        end
    end

    always_comb begin
        if (buf_q.valid) begin
            if_out = buf_q;
        end else begin
            if_out = '{valid: resp_live, pc: req_pc, inst: imem_data};
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        imem_start && !imem_ready |=> imem_start && $stable(imem_addr));

endmodule

// ==== decode/decode_stage.sv ====
module decode_stage (
    input  core_pkg::if_id_t   id_in,
    output core_pkg::reg_idx_t rs1_idx,
    output core_pkg::reg_idx_t rs2_idx,
    input  core_pkg::word_t    rs1_val,
    input  core_pkg::word_t    rs2_val,
    input  core_pkg::writer_t  ex_busy,
    input  core_pkg::writer_t  mem_busy,
    input  core_pkg::writer_t  wb_busy,
    output logic               hazard_stall,
    output core_pkg::id_ex_t   id_out
);
    import core_pkg::*;

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    word_t      inst;
    logic [2:0] funct3;
    logic       use_rs1;
    logic       use_rs2;
    ctrl_t      ctrl;
    word_t      imm;

    function automatic logic hits(reg_idx_t idx, writer_t w);
        return idx != '0 && w.busy && w.addr == idx;
    endfunction

    assign inst    = id_in.inst;
    assign funct3  = inst[14:12];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];

    always_comb begin
        ctrl.alu_op  = alu_add;
        ctrl.use_imm = 1'b0;
        ctrl.use_pc  = 1'b0;
        ctrl.mem_op  = mem_none;
        ctrl.branch  = br_none;
        ctrl.rf_wen  = 1'b0;
        ctrl.wb_addr = inst[11:7];
        ctrl.is_exit = 1'b0;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;
        imm          = {{20{inst[31]}}, inst[31:20]};
        case (inst[6:0])
            op_lui: begin
                ctrl.alu_op  = alu_pass_b;
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen  = 1'b1;
                imm          = {inst[31:12], 12'b0};
            end
            op_jal: begin
                // link is pc + 4
                ctrl.use_pc = 1'b1;
                ctrl.branch = br_jal;
                ctrl.rf_wen = 1'b1;
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            op_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    ctrl.branch = br_beq;
                end else if (funct3 == 3'b001) begin
                    ctrl.branch = br_bne;
                end
            end
            op_load: begin
                use_rs1      = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.mem_op  = mem_load;
                ctrl.rf_wen  = 1'b1;
            end
            op_store: begin
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.mem_op  = mem_store;
                imm          = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            op_imm: begin
                use_rs1      = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen  = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_add;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    default: ctrl.rf_wen = 1'b0;
                endcase
            end
            op_reg: begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                ctrl.rf_wen = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = inst[30] ? alu_sub : alu_add;
                    3'b010:  ctrl.alu_op = alu_slt;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b111:  ctrl.alu_op = alu_and;
                    default: ctrl.rf_wen = 1'b0;
                endcase
            end
            // only ECALL is decoded here
            op_system: ctrl.is_exit = inst[31:7] == '0;
            default: ;
        endcase
    end

    // no forwarding, so wait until every older writer has retired
    assign hazard_stall = id_in.valid && (
        (use_rs1 && (hits(rs1_idx, ex_busy) || hits(rs1_idx, mem_busy) ||
                     hits(rs1_idx, wb_busy))) ||
        (use_rs2 && (hits(rs2_idx, ex_busy) || hits(rs2_idx, mem_busy) ||
                     hits(rs2_idx, wb_busy))));

    always_comb begin
        id_out.valid   = id_in.valid && !hazard_stall;
        id_out.pc      = id_in.pc;
        id_out.ctrl    = ctrl;
        id_out.rs1_val = rs1_val;
        id_out.rs2_val = rs2_val;
        id_out.imm     = imm;
    end

endmodule

// ==== execute/execute_stage.sv ====
module execute_stage (
    input  core_pkg::id_ex_t  ex_in,
    output core_pkg::ex_mem_t ex_out,
    output logic              redirect,
    output core_pkg::word_t   redirect_target
);
    import core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_out;
    logic  taken;

    always_comb begin
        op_a = ex_in.ctrl.use_pc ? ex_in.pc : ex_in.rs1_val;
        if (ex_in.ctrl.use_imm) begin
            op_b = ex_in.imm;
        end else if (ex_in.ctrl.use_pc) begin
            op_b = 32'd4;
        end else begin
            op_b = ex_in.rs2_val;
        end
    end

    always_comb begin
        case (ex_in.ctrl.alu_op)
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (ex_in.ctrl.branch)
            br_beq:  taken = ex_in.rs1_val == ex_in.rs2_val;
            br_bne:  taken = ex_in.rs1_val != ex_in.rs2_val;
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect        = ex_in.valid && taken;
    assign redirect_target = ex_in.pc + ex_in.imm;

    assign ex_out = '{
        valid:      ex_in.valid,
        ctrl:       ex_in.ctrl,
        alu_out:    alu_out,
        store_data: ex_in.rs2_val
    };

endmodule

// ==== memory/memory_stage.sv ====
module memory_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  core_pkg::ex_mem_t mem_in,
    output logic              dmem_start,
    output logic              dmem_write,
    output core_pkg::word_t   dmem_addr,
    output core_pkg::word_t   dmem_wdata,
    input  logic              dmem_ready,
    input  core_pkg::word_t   dmem_rdata,
    input  logic              dmem_valid,
    output logic              mem_stall,
    output core_pkg::mem_wb_t wb_out
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_ready,
        wait_data
    } state_e;

    state_e state;
    logic   is_mem;
    logic   done;
    logic   resp_pending;

    assign is_mem = mem_in.valid && mem_in.ctrl.mem_op != mem_none;
    assign done   = state == wait_data && dmem_valid;

    // the entry stays in EX/MEM until its response is back
    assign mem_stall  = is_mem && !done;
    assign dmem_start = state == wait_ready;
    assign dmem_write = dmem_start && mem_in.ctrl.mem_op == mem_store;
    assign dmem_addr  = mem_in.alu_out;
    assign dmem_wdata = mem_in.store_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:       if (is_mem) state <= wait_ready;
                wait_ready: if (dmem_ready) state <= wait_data;
                wait_data:  if (dmem_valid) state <= idle;
                default:    state <= idle;
            endcase
        end
    end

    // accepted request still waiting for its response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_pending <= 1'b0;
        end else if (dmem_start && dmem_ready) begin
            resp_pending <= 1'b1;
        end else if (dmem_valid) begin
            resp_pending <= 1'b0;
        end
    end

    always_comb begin
        wb_out.valid   = mem_in.valid && !mem_stall;
        wb_out.rf_wen  = mem_in.ctrl.rf_wen;
        wb_out.wb_addr = mem_in.ctrl.wb_addr;
        wb_out.wb_data = mem_in.ctrl.mem_op == mem_load ? dmem_rdata : mem_in.alu_out;
        wb_out.is_exit = mem_in.ctrl.is_exit;
    end

    // one request outstanding on the data port
    assert property (@(posedge clk) disable iff (!arst_n) resp_pending |-> !dmem_start);

endmodule

// ==== verilog/core_top.sv ====
module core_top (
    input  logic            clk,
    input  logic            arst_n,

    output logic            imem_start,
    output core_pkg::word_t imem_addr,
    input  logic            imem_ready,
    input  core_pkg::word_t imem_data,
    input  logic            imem_valid,

    output logic            dmem_start,
    output logic            dmem_write,
    output core_pkg::word_t dmem_addr,
    output core_pkg::word_t dmem_wdata,
    input  logic            dmem_ready,
    input  core_pkg::word_t dmem_rdata,
    input  logic            dmem_valid,

    output logic            exit,
    output core_pkg::word_t gp
);
    import core_pkg::*;

    if_id_t   if_out;
    if_id_t   if_id_q;
    id_ex_t   id_out;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_out;
    ex_mem_t  ex_mem_q;
    ex_mem_t  mem_in;
    mem_wb_t  wb_out;
    mem_wb_t  mem_wb_q;

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_val;
    word_t    rs2_val;
    writer_t  ex_busy;
    writer_t  mem_busy;
    writer_t  wb_busy;

    logic     hazard_stall;
    logic     mem_stall;
    logic     ex_stall;
    logic     id_stall;
    logic     if_stall;
    logic     ex_redirect;
    logic     redirect;
    word_t    redirect_target;
    logic     retire_exit;
    logic     flush_all;

    // stall chain runs from memory back to fetch
    assign ex_stall = mem_stall;
    assign id_stall = ex_stall || hazard_stall;
    assign if_stall = id_stall;

    assign redirect    = ex_redirect && !ex_stall;
    assign retire_exit = mem_wb_q.valid && mem_wb_q.is_exit;
    assign flush_all   = exit || retire_exit;

    assign ex_busy  = '{busy: id_ex_q.valid && id_ex_q.ctrl.rf_wen, addr: id_ex_q.ctrl.wb_addr};
    assign mem_busy = '{busy: ex_mem_q.valid && ex_mem_q.ctrl.rf_wen, addr: ex_mem_q.ctrl.wb_addr};
    assign wb_busy  = '{busy: mem_wb_q.valid && mem_wb_q.rf_wen, addr: mem_wb_q.wb_addr};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id_q  <= '0;
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else begin
            if (flush_all || redirect) begin
                if_id_q.valid <= 1'b0;
            end else if (!if_stall) begin
                if_id_q <= if_out;
            end

            if (flush_all || redirect) begin
                id_ex_q.valid <= 1'b0;
            end else if (!ex_stall) begin
                id_ex_q <= id_out;
            end

            if (flush_all) begin
                ex_mem_q.valid <= 1'b0;
            end else if (!mem_stall) begin
                ex_mem_q <= ex_out;
            end

            // memory emits a bubble while it waits
            if (flush_all) begin
                mem_wb_q.valid <= 1'b0;
            end else begin
                mem_wb_q <= wb_out;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exit <= 1'b0;
        end else if (retire_exit) begin
            exit <= 1'b1;
        end
    end

    // entry behind a retiring ECALL must not reach the data port
    always_comb begin
        mem_in       = ex_mem_q;
        mem_in.valid = ex_mem_q.valid && !retire_exit;
    end

    fetch_stage u_fetch (
        .clk             (clk),
        .arst_n          (arst_n),
        .imem_start      (imem_start),
        .imem_addr       (imem_addr),
        .imem_ready      (imem_ready),
        .imem_data       (imem_data),
        .imem_valid      (imem_valid),
        .stall           (if_stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .halt            (flush_all),
        .if_out          (if_out)
    );

    decode_stage u_decode (
        .id_in        (if_id_q),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .ex_busy      (ex_busy),
        .mem_busy     (mem_busy),
        .wb_busy      (wb_busy),
        .hazard_stall (hazard_stall),
        .id_out       (id_out)
    );

    register_file u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wen     (mem_wb_q.valid && mem_wb_q.rf_wen),
        .waddr   (mem_wb_q.wb_addr),
        .wdata   (mem_wb_q.wb_data),
        .gp      (gp)
    );

    execute_stage u_execute (
        .ex_in           (id_ex_q),
        .ex_out          (ex_out),
        .redirect        (ex_redirect),
        .redirect_target (redirect_target)
    );

    memory_stage u_memory (
        .clk        (clk),
        .arst_n     (arst_n),
        .mem_in     (mem_in),
        .dmem_start (dmem_start),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ready (dmem_ready),
        .dmem_rdata (dmem_rdata),
        .dmem_valid (dmem_valid),
        .mem_stall  (mem_stall),
        .wb_out     (wb_out)
    );

    // nothing retires once the core has exited
    assert property (@(posedge clk) disable iff (!arst_n) exit |-> !mem_wb_q.valid);

endmodule

// ==== verif/tb_memory.sv ====
module tb_memory #(
    parameter logic [31:0] val_a       = 32'h0000_0123,
    parameter logic [31:0] val_b       = 32'h0000_0045,
    parameter logic [19:0] val_c       = 20'h12345,
    parameter logic [11:0] res_base    = 12'h100,
    parameter logic [11:0] poison_addr = 12'h1f0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        imem_start,
    input  logic [31:0] imem_addr,
    output logic        imem_ready,
    output logic [31:0] imem_data,
    output logic        imem_valid,
    input  logic        dmem_start,
    input  logic        dmem_write,
    input  logic [31:0] dmem_addr,
    input  logic [31:0] dmem_wdata,
    output logic        dmem_ready,
    output logic [31:0] dmem_rdata,
    output logic        dmem_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] rom [64];
    logic [31:0] ram [128];
    logic        i_acc;
    logic [31:0] i_acc_addr;
    logic        d_acc;
    logic [31:0] d_acc_addr;
    logic        i_busy;
    logic        d_busy;
    logic [31:0] i_addr_q;
    logic [31:0] d_addr_q;
    int          i_cnt;
    int          d_cnt;
    int          i_rwait;
    int          d_rwait;

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    initial begin
        // unused slots hold a NOP whose immediate is the word index
        for (int i = 0; i < 64; i++) begin
            rom[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011);
        end
        for (int i = 0; i < 128; i++) begin
            ram[i] = 32'hc0de_0000 ^ (i * 4);
        end
        // x12 holds the 0xdead marker
        rom[0]  = {20'h0000e, 5'd12, 7'b0110111};
        rom[1]  = i_type(12'head, 5'd12, 3'b000, 5'd12, 7'b0010011);
        rom[2]  = i_type(val_a[11:0], 5'd0, 3'b000, 5'd1, 7'b0010011);
        rom[3]  = i_type(val_b[11:0], 5'd0, 3'b000, 5'd2, 7'b0010011);
        rom[4]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4);
        rom[5]  = s_type(res_base + 12'h00, 5'd4, 5'd0);
        rom[6]  = r_type(7'h20, 5'd2, 5'd4, 3'b000, 5'd5);
        rom[7]  = s_type(res_base + 12'h04, 5'd5, 5'd0);
        rom[8]  = r_type(7'h00, 5'd1, 5'd4, 3'b111, 5'd6);
        rom[9]  = s_type(res_base + 12'h08, 5'd6, 5'd0);
        rom[10] = r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd7);
        rom[11] = s_type(res_base + 12'h0c, 5'd7, 5'd0);
        rom[12] = r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd8);
        rom[13] = s_type(res_base + 12'h10, 5'd8, 5'd0);
        rom[14] = r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd9);
        rom[15] = s_type(res_base + 12'h14, 5'd9, 5'd0);
        rom[16] = {val_c, 5'd10, 7'b0110111};
        rom[17] = s_type(res_base + 12'h18, 5'd10, 5'd0);
        rom[18] = i_type(res_base, 5'd0, 3'b010, 5'd11, 7'b0000011);
        rom[19] = s_type(res_base + 12'h1c, 5'd11, 5'd0);
        // taken BEQ skips a poison store
        rom[20] = b_type(13'd8, 5'd5, 5'd1, 3'b000);
        rom[21] = s_type(poison_addr, 5'd12, 5'd0);
        rom[22] = b_type(13'd8, 5'd5, 5'd1, 3'b001);
        rom[23] = i_type(12'd7, 5'd0, 3'b000, 5'd14, 7'b0010011);
        rom[24] = s_type(res_base + 12'h20, 5'd14, 5'd0);
        rom[25] = j_type(21'd8, 5'd13);
        rom[26] = s_type(poison_addr, 5'd12, 5'd0);
        rom[27] = s_type(res_base + 12'h24, 5'd13, 5'd0);
        // checksum in gp
        rom[28] = r_type(7'h00, 5'd7, 5'd4, 3'b000, 5'd3);
        rom[29] = r_type(7'h00, 5'd11, 5'd3, 3'b000, 5'd3);
        rom[30] = 32'h0000_0073;
    end

    initial begin
        imem_ready = 1'b0;
        imem_data  = '0;
        imem_valid = 1'b0;
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        dmem_valid = 1'b0;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            i_acc <= 1'b0;
            d_acc <= 1'b0;
        end else begin
            i_acc      <= imem_start && imem_ready;
            i_acc_addr <= imem_addr;
            d_acc      <= dmem_start && dmem_ready;
            d_acc_addr <= dmem_addr;
            if (dmem_start && dmem_ready && dmem_write) begin
                ram[dmem_addr[8:2]] <= dmem_wdata;
            end
        end
    end

    always @(negedge clk) begin
        if (!arst_n) begin
            imem_ready = 1'b0;
            imem_valid = 1'b0;
            i_busy     = 1'b0;
            i_rwait    = 0;
        end else begin
            imem_valid = 1'b0;
            if (i_acc) begin
                i_busy   = 1'b1;
                i_cnt    = $urandom % 4;
                i_addr_q = i_acc_addr;
            end
            if (i_busy) begin
                if (i_cnt == 0) begin
                    imem_data  = rom[i_addr_q[7:2]];
                    imem_valid = 1'b1;
                    i_busy     = 1'b0;
                end else begin
                    i_cnt--;
                end
            end
            if (imem_start && i_rwait == 0) begin
                imem_ready = 1'b1;
            end else if (imem_start) begin
                imem_ready = 1'b0;
                i_rwait--;
            end else begin
                imem_ready = 1'b0;
                i_rwait    = $urandom % 4;
            end
        end
    end

    always @(negedge clk) begin
        if (!arst_n) begin
            dmem_ready = 1'b0;
            dmem_valid = 1'b0;
            d_busy     = 1'b0;
            d_rwait    = 0;
        end else begin
            dmem_valid = 1'b0;
            if (d_acc) begin
                d_busy   = 1'b1;
                d_cnt    = $urandom % 4;
                d_addr_q = d_acc_addr;
            end
            if (d_busy) begin
                if (d_cnt == 0) begin
                    dmem_rdata = ram[d_addr_q[8:2]];
                    dmem_valid = 1'b1;
                    d_busy     = 1'b0;
                end else begin
                    d_cnt--;
                end
            end
            if (dmem_start && d_rwait == 0) begin
                dmem_ready = 1'b1;
            end else if (dmem_start) begin
                dmem_ready = 1'b0;
                d_rwait--;
            end else begin
                dmem_ready = 1'b0;
                d_rwait    = $urandom % 4;
            end
        end
    end

endmodule

// ==== verif/tb_core.sv ====
module tb_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] val_a       = 32'h0000_0123;
    localparam logic [31:0] val_b       = 32'h0000_0045;
    localparam logic [19:0] val_c       = 20'h12345;
    localparam logic [11:0] res_base    = 12'h100;
    localparam logic [11:0] poison_addr = 12'h1f0;
    localparam int          num_stores  = 10;
    localparam int          max_cycles  = 4000;
    // JAL sits at word 25
    localparam logic [31:0] link_value  = 32'd25 * 4 + 4;
    localparam logic [31:0] checksum    = (val_a + val_b) + (val_a | val_b) + (val_a + val_b);

    logic        clk;
    logic        arst_n;
    logic        imem_start;
    logic [31:0] imem_addr;
    logic        imem_ready;
    logic [31:0] imem_data;
    logic        imem_valid;
    logic        dmem_start;
    logic        dmem_write;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_ready;
    logic [31:0] dmem_rdata;
    logic        dmem_valid;
    logic        exit;
    logic [31:0] gp;
    logic        store_fire;
    int          store_idx;
    int          cycles;

    function automatic logic [31:0] store_addr(int i);
        return 32'(res_base) + 32'(i * 4);
    endfunction

    function automatic logic [31:0] store_value(int i);
        case (i)
            0:       return val_a + val_b;
            1:       return val_a;
            2:       return (val_a + val_b) & val_a;
            3:       return val_a | val_b;
            4:       return val_a ^ val_b;
            5:       return ($signed(val_b) < $signed(val_a)) ? 32'd1 : 32'd0;
            6:       return {val_c, 12'h000};
            7:       return val_a + val_b;
            8:       return 32'd7;
            9:       return link_value;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic string store_name(int i);
        case (i)
            0:       return "add";
            1:       return "sub";
            2:       return "and";
            3:       return "or";
            4:       return "xor";
            5:       return "slt";
            6:       return "lui";
            7:       return "load_store";
            8:       return "bne_not_taken";
            9:       return "jal_link";
            default: return "extra_store";
        endcase
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        $display("Done: errors found");
        $fatal(1);
    endtask

    core_top DUT (.*);

    tb_memory #(
        .val_a       (val_a),
        .val_b       (val_b),
        .val_c       (val_c),
        .res_base    (res_base),
        .poison_addr (poison_addr)
    ) u_mem (.*);

    always #4 clk = ~clk;

    assign store_fire = dmem_start && dmem_ready && dmem_write;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            store_idx <= 0;
        end else if (store_fire) begin
            store_idx <= store_idx + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            report_failure("timeout: the core did not exit in time");
        end
    end

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !imem_start && !dmem_start && !exit)
        else report_failure("a port or exit was active during reset");

    after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !imem_start && !dmem_start && !exit)
        else report_failure("imem_start, dmem_start or exit was high right after reset");

    // start and address hold until the request is taken
    imem_hold: assert property (@(posedge clk) disable iff (!arst_n)
        imem_start && !imem_ready |=> imem_start && $stable(imem_addr))
        else report_failure("imem_start or imem_addr changed before the request was accepted");

    dmem_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_start && !dmem_ready |=>
            dmem_start && $stable(dmem_addr) && $stable(dmem_write) && $stable(dmem_wdata))
        else report_failure("a data request changed before it was accepted");

    extra_store: assert property (@(posedge clk) disable iff (!arst_n)
        store_fire |-> store_idx < num_stores)
        else report_failure("more stores than the program issues");

    store_address: assert property (@(posedge clk) disable iff (!arst_n)
        store_fire |-> dmem_addr == store_addr(store_idx))
        else report_mismatch({store_name($sampled(store_idx)), "_addr"},
                             store_addr($sampled(store_idx)), $sampled(dmem_addr));

    store_data: assert property (@(posedge clk) disable iff (!arst_n)
        store_fire |-> dmem_wdata == store_value(store_idx))
        else report_mismatch(store_name($sampled(store_idx)),
                             store_value($sampled(store_idx)), $sampled(dmem_wdata));

    // a skipped slot stores the marker here
    no_poison: assert property (@(posedge clk) disable iff (!arst_n)
        store_fire |-> dmem_addr != 32'(poison_addr))
        else report_failure("a store reached the poison address");

    exit_gp: assert property (@(posedge clk) disable iff (!arst_n) $rose(exit) |-> gp == checksum)
        else report_mismatch("exit_checksum", checksum, $sampled(gp));

    quiet_after_exit: assert property (@(posedge clk) disable iff (!arst_n) exit |-> !dmem_start)
        else report_failure("dmem_start was raised after exit");

    initial begin
        void'($urandom(32'he4b6));
        clk    = 1'b0;
        arst_n = 1'b0;
        cycles = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        wait (exit);
        // let the post-exit checks sample for a while
        repeat (20) @(posedge clk);
        @(negedge clk);
        if (store_idx != num_stores) begin
            $display("mismatch store_count expected %0d actual %0d", num_stores, store_idx);
            $display("Done: errors found");
            $fatal(1);
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
+incdir+common
common/core_pkg.sv
verilog/register_file.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/memory_stage.sv
verilog/core_top.sv
verif/tb_memory.sv
verif/tb_core.sv

// ==== Makefile ====
SIM := obj_dir/tb_core_sim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): tb.f
	verilator --binary --timing --assert -f tb.f --top-module tb_core -o tb_core_sim

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
